// ==== hw/md_pkg.sv ====
// ----------------------------------------------------------------------
// Shared widths, vector types and request format of the RV32M
// multiply/divide unit. All widths assume a 32-bit datapath split into
// 16-bit halves for the multiplier.
// ----------------------------------------------------------------------

package md_pkg;

  localparam int unsigned WORD_W    = 32;
  localparam int unsigned HALF_W    = 16;
  // Word plus two guard bits for carries and sign
  localparam int unsigned EXT_W     = 34;
  localparam int unsigned DIV_STEPS = 32;

  typedef logic [WORD_W-1:0]            word_t;
  typedef logic [HALF_W-1:0]            half_t;
  typedef logic [EXT_W-1:0]             ext_t;
  typedef logic [$clog2(DIV_STEPS)-1:0] count_t;

  // Bit 0 marks operand a as signed, bit 1 marks operand b as signed
  typedef logic [1:0] sign_mode_t;

  // MULH covers MULH, MULHSU and MULHU through the sign mode
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  typedef struct packed {
    md_op_e     op;
    sign_mode_t signed_mode;
    word_t      op_a;
    word_t      op_b;
  } md_req_t;

endpackage

// ==== hw/md_mac_mult.sv ====
// ----------------------------------------------------------------------
// Sequential multiplier around one 17x17 signed MAC. MUL is valid in
// the third cycle of the enable, MULH/MULHSU/MULHU in the fourth.
// Request and enable must stay stable until valid and ready meet.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module md_mac_mult (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            en_i,
  input  md_pkg::md_req_t req_i,
  input  logic            ready_i,
  output md_pkg::word_t   result_o,
  output logic            valid_o
);

  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  mult_state_e   state_q, state_d;
  md_pkg::ext_t  acc_q, acc_d;
  md_pkg::ext_t  accum;
  md_pkg::ext_t  mac_res;
  md_pkg::half_t mul_a, mul_b;
  md_pkg::half_t a_lo, a_hi, b_lo, b_hi;
  logic          sign_a, sign_b;
  logic          signed_mult;
  logic          hold;

  assign a_lo = req_i.op_a[md_pkg::HALF_W-1:0];
  assign a_hi = req_i.op_a[md_pkg::WORD_W-1:md_pkg::HALF_W];
  assign b_lo = req_i.op_b[md_pkg::HALF_W-1:0];
  assign b_hi = req_i.op_b[md_pkg::WORD_W-1:md_pkg::HALF_W];

  assign signed_mult = (req_i.signed_mode != 2'b00);

  // 17x17 signed product plus accumulator, evaluated at 34 bits
  assign mac_res = $signed({sign_a, mul_a}) * $signed({sign_b, mul_b}) + $signed(accum);

  always_comb begin
    mul_a   = a_lo;
    mul_b   = b_lo;
    sign_a  = 1'b0;
    sign_b  = 1'b0;
    accum   = '0;
    acc_d   = mac_res;
    state_d = state_q;
    valid_o = 1'b0;
    hold    = 1'b0;

    case (state_q)
      ALBL: begin
        state_d = ALBH;
      end

      ALBH: begin
        mul_b  = b_hi;
        sign_b = req_i.signed_mode[1] & req_i.op_b[md_pkg::WORD_W-1];
        // Upper half of al*bl, always unsigned
        accum  = {{(md_pkg::EXT_W-md_pkg::HALF_W){1'b0}},
                  acc_q[md_pkg::WORD_W-1:md_pkg::HALF_W]};
        if (req_i.op == md_pkg::MD_OP_MULL) begin
          acc_d = {2'b00, mac_res[md_pkg::HALF_W-1:0], acc_q[md_pkg::HALF_W-1:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        mul_a  = a_hi;
        sign_a = req_i.signed_mode[0] & req_i.op_a[md_pkg::WORD_W-1];
        if (req_i.op == md_pkg::MD_OP_MULL) begin
          accum   = {{(md_pkg::EXT_W-md_pkg::HALF_W){1'b0}},
                     acc_q[md_pkg::WORD_W-1:md_pkg::HALF_W]};
          acc_d   = {2'b00, mac_res[md_pkg::HALF_W-1:0], acc_q[md_pkg::HALF_W-1:0]};
          valid_o = 1'b1;
          hold    = ~ready_i;
          state_d = ALBL;
        end else begin
          accum   = acc_q;
          state_d = AHBH;
        end
      end

      AHBH: begin
        mul_a  = a_hi;
        mul_b  = b_hi;
        sign_a = req_i.signed_mode[0] & req_i.op_a[md_pkg::WORD_W-1];
        sign_b = req_i.signed_mode[1] & req_i.op_b[md_pkg::WORD_W-1];
        // Shift the partial sum down one half, extend its sign if any operand is signed
        accum  = {{(md_pkg::EXT_W-md_pkg::HALF_W-2){signed_mult & acc_q[md_pkg::EXT_W-1]}},
                  acc_q[md_pkg::EXT_W-1:md_pkg::HALF_W]};
        valid_o = 1'b1;
        hold    = ~ready_i;
        state_d = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  // Low word of the final MAC step is the result in both finishing states
  assign result_o = acc_d[md_pkg::WORD_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
      acc_q   <= '0;
    end else if (en_i && !hold) begin
      state_q <= state_d;
      acc_q   <= acc_d;
    end
  end

endmodule

// ==== hw/md_long_div.sv ====
// ----------------------------------------------------------------------
// Long divider, one quotient bit per cycle on absolute values with a
// final sign fix. Normal divisions are valid in cycle 37 of the enable,
// division by zero in cycle 2 with the RV32M results.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module md_long_div (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            en_i,
  input  md_pkg::md_req_t req_i,
  input  logic            ready_i,
  output md_pkg::word_t   result_o,
  output logic            valid_o
);

  typedef enum logic [2:0] {
    MD_IDLE,
    MD_ABS_A,
    MD_ABS_B,
    MD_COMP,
    MD_LAST,
    MD_CHANGE_SIGN,
    MD_FINISH
  } div_state_e;

  div_state_e     state_q, state_d;
  md_pkg::ext_t   rem_q, rem_d;
  md_pkg::word_t  num_q, num_d;
  md_pkg::word_t  den_q, den_d;
  md_pkg::word_t  quot_q, quot_d;
  md_pkg::count_t cnt_q, cnt_d;
  logic           div_by_zero_q, div_by_zero_d;

  // Shared 33-bit subtractor, sum holds a - b in [32:0] and no-borrow in [33]
  logic [md_pkg::WORD_W:0] adder_a, adder_b;
  md_pkg::ext_t            adder_sum;
  logic [md_pkg::WORD_W:0] adder_res;
  logic                    adder_carry;

  logic                    sign_a, sign_b;
  logic                    div_change_sign, rem_change_sign;
  logic                    is_greater_equal;
  logic [md_pkg::WORD_W:0] next_rem;
  md_pkg::word_t           next_quot;
  logic                    hold;

  assign adder_sum   = {1'b0, adder_a} + {1'b0, ~adder_b} + md_pkg::ext_t'(1);
  assign adder_res   = adder_sum[md_pkg::WORD_W:0];
  assign adder_carry = adder_sum[md_pkg::EXT_W-1];

  assign sign_a          = req_i.signed_mode[0] & req_i.op_a[md_pkg::WORD_W-1];
  assign sign_b          = req_i.signed_mode[1] & req_i.op_b[md_pkg::WORD_W-1];
  assign div_change_sign = (sign_a ^ sign_b) & ~div_by_zero_q;
  assign rem_change_sign = sign_a;

  // Both values are non-negative here, so no borrow means remainder >= divisor
  assign is_greater_equal = adder_carry;
  assign next_rem  = is_greater_equal ? adder_res : rem_q[md_pkg::WORD_W:0];
  assign next_quot = quot_q | (md_pkg::word_t'(is_greater_equal) << cnt_q);

  always_comb begin
    adder_a       = '0;
    adder_b       = {1'b0, req_i.op_b};
    rem_d         = rem_q;
    num_d         = num_q;
    den_d         = den_q;
    quot_d        = quot_q;
    cnt_d         = cnt_q - md_pkg::count_t'(1);
    div_by_zero_d = div_by_zero_q;
    state_d       = state_q;
    valid_o       = 1'b0;
    hold          = 1'b0;

    case (state_q)
      MD_IDLE: begin
        // 0 - b leaves no borrow only when b is zero
        div_by_zero_d = adder_carry;
        if (req_i.op == md_pkg::MD_OP_DIV) begin
          rem_d = '1;
        end else begin
          rem_d = {2'b00, req_i.op_a};
        end
        cnt_d   = md_pkg::count_t'(md_pkg::DIV_STEPS - 1);
        state_d = adder_carry ? MD_FINISH : MD_ABS_A;
      end

      MD_ABS_A: begin
        adder_b = {1'b0, req_i.op_a};
        quot_d  = '0;
        num_d   = sign_a ? adder_res[md_pkg::WORD_W-1:0] : req_i.op_a;
        state_d = MD_ABS_B;
      end

      MD_ABS_B: begin
        // First partial remainder is the top numerator bit
        rem_d   = {{(md_pkg::EXT_W-1){1'b0}}, num_q[md_pkg::WORD_W-1]};
        den_d   = sign_b ? adder_res[md_pkg::WORD_W-1:0] : req_i.op_b;
        cnt_d   = md_pkg::count_t'(md_pkg::DIV_STEPS - 1);
        state_d = MD_COMP;
      end

      MD_COMP: begin
        adder_a = rem_q[md_pkg::WORD_W:0];
        adder_b = {1'b0, den_q};
        rem_d   = {next_rem, num_q[cnt_d]};
        quot_d  = next_quot;
        state_d = (cnt_q == md_pkg::count_t'(1)) ? MD_LAST : MD_COMP;
      end

      MD_LAST: begin
        adder_a = rem_q[md_pkg::WORD_W:0];
        adder_b = {1'b0, den_q};
        // From here on the register carries only the selected result
        if (req_i.op == md_pkg::MD_OP_DIV) begin
          rem_d = {2'b00, next_quot};
        end else begin
          rem_d = {2'b00, next_rem[md_pkg::WORD_W-1:0]};
        end
        state_d = MD_CHANGE_SIGN;
      end

      MD_CHANGE_SIGN: begin
        adder_b = {1'b0, rem_q[md_pkg::WORD_W-1:0]};
        if (req_i.op == md_pkg::MD_OP_DIV) begin
          if (div_change_sign) begin
            rem_d = {2'b00, adder_res[md_pkg::WORD_W-1:0]};
          end
        end else begin
          if (rem_change_sign) begin
            rem_d = {2'b00, adder_res[md_pkg::WORD_W-1:0]};
          end
        end
        state_d = MD_FINISH;
      end

      MD_FINISH: begin
        valid_o = 1'b1;
        hold    = ~ready_i;
        state_d = MD_IDLE;
      end

      default: begin
        state_d = MD_IDLE;
      end
    endcase
  end

  assign result_o = rem_q[md_pkg::WORD_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= MD_IDLE;
      rem_q         <= '0;
      num_q         <= '0;
      den_q         <= '0;
      quot_q        <= '0;
      cnt_q         <= '0;
      div_by_zero_q <= 1'b0;
    end else if (en_i && !hold) begin
      state_q       <= state_d;
      rem_q         <= rem_d;
      num_q         <= num_d;
      den_q         <= den_d;
      quot_q        <= quot_d;
      cnt_q         <= cnt_d;
      div_by_zero_q <= div_by_zero_d;
    end
  end

endmodule

// ==== hw/md_unit.sv ====
// ----------------------------------------------------------------------
// RV32M multiply/divide unit. At most one of mult_en_i and div_en_i may
// be high; operands stay stable until valid_o and ready_i meet. Timing
// is that of the enabled engine, with no added cycles.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module md_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               mult_en_i,
  input  logic               div_en_i,
  input  md_pkg::md_op_e     operator_i,
  input  md_pkg::sign_mode_t signed_mode_i,
  input  md_pkg::word_t      op_a_i,
  input  md_pkg::word_t      op_b_i,
  input  logic               ready_i,
  output md_pkg::word_t      result_o,
  output logic               valid_o
);

  md_pkg::md_req_t req;
  md_pkg::word_t   mult_result;
  md_pkg::word_t   div_result;
  logic            mult_valid;
  logic            div_valid;

  assign req = '{
    op:          operator_i,
    signed_mode: signed_mode_i,
    op_a:        op_a_i,
    op_b:        op_b_i
  };

  md_mac_mult md_mac_mult_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (mult_en_i),
    .req_i    (req),
    .ready_i  (ready_i),
    .result_o (mult_result),
    .valid_o  (mult_valid)
  );

  md_long_div md_long_div_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (div_en_i),
    .req_i    (req),
    .ready_i  (ready_i),
    .result_o (div_result),
    .valid_o  (div_valid)
  );

  // The active enable picks the result
  assign result_o = div_en_i ? div_result : mult_result;
  assign valid_o  = mult_valid | div_valid;

endmodule

// ==== test/md_tb.sv ====
// ----------------------------------------------------------------------
// Testbench for md_unit. Run from the project root so that
// test/md_input.txt is found. Each vector is checked for result,
// latency and stable outputs under random ready_i back-pressure.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module md_tb;

  localparam int unsigned CLK_PERIOD     = 4;
  localparam int unsigned RESET_CYCLES   = 2;
  // Longest operation, longest stall and two spare cycles
  localparam int unsigned CYCLES_PER_VEC = 37 + 3 + 2;
  localparam int unsigned NO_VALID_LIMIT = 64;

  typedef struct packed {
    md_pkg::md_op_e     op;
    md_pkg::sign_mode_t mode;
    md_pkg::word_t      a;
    md_pkg::word_t      b;
    md_pkg::word_t      result;
    logic [7:0]         latency;
  } vector_t;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic               mult_en_i;
  logic               div_en_i;
  md_pkg::md_op_e     operator_i;
  md_pkg::sign_mode_t signed_mode_i;
  md_pkg::word_t      op_a_i;
  md_pkg::word_t      op_b_i;
  logic               ready_i;
  md_pkg::word_t      result_o;
  logic               valid_o;

  vector_t            vectors[$];
  logic               vectors_loaded = 1'b0;
  int unsigned        pass_count;
  int unsigned        fail_count;
  integer             seed;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  md_unit md_unit_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mult_en_i     (mult_en_i),
    .div_en_i      (div_en_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .ready_i       (ready_i),
    .result_o      (result_o),
    .valid_o       (valid_o)
  );

  task automatic load_vectors();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] op_f, mode_f, a_f, b_f, res_f;
    int          lat_f;
    vector_t     vec;
    fd = $fopen("test/md_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file test/md_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Lines starting with # describe the columns
        if (line.len() > 1 && line[0] != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h %d", op_f, mode_f, a_f, b_f, res_f, lat_f);
          if (fields == 6) begin
            vec.op      = md_pkg::md_op_e'(op_f[1:0]);
            vec.mode    = mode_f[1:0];
            vec.a       = a_f;
            vec.b       = b_f;
            vec.result  = res_f;
            vec.latency = lat_f[7:0];
            vectors.push_back(vec);
          end else begin
            $display("Malformed line in the vector file: %s", line);
            fail_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_idle(input string where);
    assert (valid_o == 1'b0) else begin
      $display("FAILED valid_o %s: expected %h, got %h", where, 1'b0, valid_o);
      fail_count++;
    end
    if (valid_o == 1'b0) begin
      pass_count++;
      $display("idle check %s: ok", where);
    end
  endtask

  task automatic run_vector(input int unsigned idx, input vector_t vec);
    int unsigned   stall_target;
    int unsigned   stalls;
    int unsigned   cycles;
    int unsigned   latency;
    int unsigned   errors;
    md_pkg::word_t first_result;
    logic          is_mult;
    logic          done;
    stall_target = $random(seed) & 32'h3;
    stalls       = 0;
    cycles       = 0;
    latency      = 0;
    errors       = 0;
    first_result = '0;
    done         = 1'b0;
    is_mult = (vec.op == md_pkg::MD_OP_MULL) || (vec.op == md_pkg::MD_OP_MULH);
    mult_en_i     <= is_mult;
    div_en_i      <= !is_mult;
    operator_i    <= vec.op;
    signed_mode_i <= vec.mode;
    op_a_i        <= vec.a;
    op_b_i        <= vec.b;
    ready_i       <= (stall_target == 0);

    while (!done) begin
      @(negedge clk_i);
      cycles++;
      if (latency != 0) begin
        // Result is held while ready_i is low
        assert (valid_o) else begin
          $display("FAILED valid_o vector %0d held: expected %h, got %h",
                   idx, 1'b1, valid_o);
          errors++;
        end
        assert (result_o == first_result) else begin
          $display("FAILED result_o vector %0d held: expected %h, got %h",
                   idx, first_result, result_o);
          errors++;
        end
      end else if (valid_o) begin
        latency      = cycles;
        first_result = result_o;
      end
      assert (cycles < NO_VALID_LIMIT) else begin
        $display("Vector %0d: no handshake within %0d cycles", idx, NO_VALID_LIMIT);
        errors++;
      end
      if (valid_o && ready_i) begin
        done = 1'b1;
      end else if (valid_o) begin
        stalls++;
      end else if (latency != 0 || cycles >= NO_VALID_LIMIT) begin
        done = 1'b1;
      end
      @(posedge clk_i);
      if (!done && latency != 0 && stalls == stall_target) begin
        ready_i <= 1'b1;
      end
    end

    assert (first_result == vec.result) else begin
      $display("FAILED result_o vector %0d: expected %h, got %h", idx, vec.result, first_result);
      errors++;
    end
    assert (latency == vec.latency) else begin
      $display("FAILED valid_o latency vector %0d: expected %h, got %h",
               idx, vec.latency, latency);
      errors++;
    end
    if (errors == 0) begin
      pass_count++;
      $display("vector %0d op %0d mode %0d a %h b %h: ok, %0d cycles, %0d stalls",
               idx, vec.op, vec.mode, vec.a, vec.b, latency, stalls);
    end else begin
      fail_count++;
      $display("vector %0d op %0d mode %0d a %h b %h: %0d errors",
               idx, vec.op, vec.mode, vec.a, vec.b, errors);
    end
  endtask

  initial begin : main
    seed          = 32'h4b43f430;
    rst_ni        = 1'b0;
    mult_en_i     = 1'b0;
    div_en_i      = 1'b0;
    operator_i    = md_pkg::MD_OP_MULL;
    signed_mode_i = '0;
    op_a_i        = '0;
    op_b_i        = '0;
    ready_i       = 1'b0;
    pass_count    = 0;
    fail_count    = 0;
    load_vectors();
    vectors_loaded = 1'b1;

    if (vectors.size() == 0) begin
      $display("No test vectors were loaded");
      fail_count++;
    end else begin
      repeat (RESET_CYCLES) @(posedge clk_i);
      rst_ni <= 1'b1;
      @(negedge clk_i);
      check_idle("after reset");
      @(posedge clk_i);
      foreach (vectors[i]) begin
        run_vector(i, vectors[i]);
      end
      mult_en_i <= 1'b0;
      div_en_i  <= 1'b0;
      ready_i   <= 1'b0;
      @(negedge clk_i);
      check_idle("after the last vector");
    end

    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Limit scales with the number of vectors read
  initial begin : watchdog
    longint unsigned limit_ns;
    wait (vectors_loaded);
    limit_ns = vectors.size() * CYCLES_PER_VEC * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
    #(limit_ns);
    $display("Simulation timed out after %0d ns before all vectors finished", limit_ns);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== compile.f ====
hw/md_pkg.sv
hw/md_mac_mult.sv
hw/md_long_div.sv
hw/md_unit.sv
test/md_tb.sv

// ==== Bender.yml ====
package:
  name: md_unit

sources:
  - files:
      - hw/md_pkg.sv
      - hw/md_mac_mult.sv
      - hw/md_long_div.sv
      - hw/md_unit.sv
  - target: test
    files:
      - test/md_tb.sv

// ==== test/md_input.txt ====
# op mode op_a op_b expected_result latency (hex, hex, hex, hex, hex, decimal cycles)
# op 0 MUL, 1 MULH, 2 DIV, 3 REM; mode bit 0 = a signed, bit 1 = b signed
0 3 00000003 00000007 00000015 3
0 3 FFFFFFFF FFFFFFFF 00000001 3
0 3 80000000 FFFFFFFF 80000000 3
0 3 12345678 00010000 56780000 3
0 3 FFFFFFFE 00000005 FFFFFFF6 3
0 3 0000FFFF 0000FFFF FFFE0001 3
0 0 FFFFFFFF 00000002 FFFFFFFE 3
0 3 7FFFFFFF 7FFFFFFF 00000001 3
0 3 00010001 00010001 00020001 3
0 3 DEADBEEF 00000000 00000000 3
0 3 80000000 80000000 00000000 3
0 3 00001234 00001000 01234000 3
1 3 FFFFFFFF FFFFFFFF 00000000 4
1 3 80000000 80000000 40000000 4
1 3 80000000 FFFFFFFF 00000000 4
1 3 7FFFFFFF 7FFFFFFF 3FFFFFFF 4
1 3 FFFFFFFE 00000005 FFFFFFFF 4
1 3 80000000 7FFFFFFF C0000000 4
1 3 00010000 00010000 00000001 4
1 3 12345678 00000000 00000000 4
1 1 FFFFFFFF FFFFFFFF FFFFFFFF 4
1 1 80000000 FFFFFFFF 80000000 4
1 1 7FFFFFFF FFFFFFFF 7FFFFFFE 4
1 1 FFFFFFFE 00000003 FFFFFFFF 4
1 1 00000002 80000000 00000001 4
1 1 FFFFFFFF 00000000 00000000 4
1 0 FFFFFFFF FFFFFFFF FFFFFFFE 4
1 0 80000000 80000000 40000000 4
1 0 80000000 FFFFFFFF 7FFFFFFF 4
1 0 00010000 00010000 00000001 4
1 0 FFFFFFFF 00000002 00000001 4
1 0 0000FFFF 00010001 00000000 4
2 3 00000014 00000006 00000003 37
2 3 FFFFFFEC 00000006 FFFFFFFD 37
2 3 00000014 FFFFFFFA FFFFFFFD 37
2 3 FFFFFFEC FFFFFFFA 00000003 37
2 3 80000000 FFFFFFFF 80000000 37
2 3 80000000 00000001 80000000 37
2 3 7FFFFFFF 00000002 3FFFFFFF 37
2 3 00000005 0000000A 00000000 37
2 3 80000000 00000002 C0000000 37
2 3 00000014 00000000 FFFFFFFF 2
2 3 80000000 00000000 FFFFFFFF 2
2 0 FFFFFFEC 00000006 2AAAAAA7 37
2 0 FFFFFFFF 00000001 FFFFFFFF 37
2 0 80000000 FFFFFFFF 00000000 37
2 0 FFFFFFFF FFFFFFFF 00000001 37
2 0 12345678 00000010 01234567 37
2 0 00000007 00000000 FFFFFFFF 2
3 3 00000014 00000006 00000002 37
3 3 FFFFFFEC 00000006 FFFFFFFE 37
3 3 00000014 FFFFFFFA 00000002 37
3 3 FFFFFFEC FFFFFFFA FFFFFFFE 37
3 3 80000000 FFFFFFFF 00000000 37
3 3 80000001 00000002 FFFFFFFF 37
3 3 FFFFFFEC 00000000 FFFFFFEC 2
3 0 FFFFFFEC 00000006 00000002 37
3 0 12345678 00000010 00000008 37
3 0 FFFFFFFF FFFFFFFE 00000001 37
3 0 DEADBEEF 00000000 DEADBEEF 2
